//--- project.f
halli_pkg.sv
card_dealer.sv
card_table.sv
bell_judge.sv
score_board.sv
halli_top.sv
tb_halli.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_halli --Mdir obj_dir

out=$(./obj_dir/Vtb_halli)
echo "$out"

if grep -q "^STATUS: PASS$" <<< "$out"; then
    exit 0
else
    exit 1
fi

//--- tb_halli.sv
`timescale 1ns/1ps

module tb_halli import halli_pkg::*; ();

    localparam score_t MARGIN          = 8'd50;
    localparam int     DEAL_CAP        = 32;
    localparam int     RING_CAP        = 8;
    localparam int     WATCHDOG_CYCLES = 2000;  // capped loops stay near 1000 cycles

    logic    clk;
    logic    rst;
    logic    deal;
    key_t    keypad;
    color_t  a_color;
    number_t a_number;
    logic    a_shown;
    color_t  b_color;
    number_t b_number;
    logic    b_shown;
    score_t  pile_count;
    logic    claim;
    logic    claim_who;
    logic    claim_right;
    score_t  score_a;
    score_t  score_b;
    winner_t winner;

    // reference model state
    logic [7:0] m_lfsr;
    logic       m_owner;
    color_t     m_a_color;
    color_t     m_b_color;
    number_t    m_a_number;
    number_t    m_b_number;
    logic       m_a_shown;
    logic       m_b_shown;
    score_t     m_pile;
    score_t     m_sa;
    score_t     m_sb;
    winner_t    m_win;

    int errors;
    int test_start;
    int tests_run;
    int tests_failed;

    halli_top i_halli_top (
        .clk         (clk),
        .rst         (rst),
        .deal        (deal),
        .keypad      (keypad),
        .a_color     (a_color),
        .a_number    (a_number),
        .a_shown     (a_shown),
        .b_color     (b_color),
        .b_number    (b_number),
        .b_shown     (b_shown),
        .pile_count  (pile_count),
        .claim       (claim),
        .claim_who   (claim_who),
        .claim_right (claim_right),
        .score_a     (score_a),
        .score_b     (score_b),
        .winner      (winner)
    );

    always #50 clk = ~clk;

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("error: run timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%02h, expected 0x%02h", name, got, exp);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};  // taps 8,6,5,4
    endfunction

    // ring rule on the model's table
    function automatic logic rule_holds();
        int na;
        int nb;
        na = int'(m_a_number);
        nb = int'(m_b_number);
        if (!m_a_shown || !m_b_shown) return 1'b0;
        if (m_a_color == m_b_color) return (na + nb == 5);
        return (na == 5) || (nb == 5);
    endfunction

    function automatic winner_t winner_for(input score_t sa, input score_t sb);
        score_t a_lim;
        score_t b_lim;
        a_lim = sb + MARGIN;
        b_lim = sa + MARGIN;
        if (sa > a_lim) return WIN_A;
        if (sb > b_lim) return WIN_B;
        return WIN_NONE;
    endfunction

    task automatic apply_reset();
        rst    = 1'b0;
        deal   = 1'b0;
        keypad = '0;
        repeat (10) @(posedge clk);
        #1;
        rst        = 1'b1;
        m_lfsr     = 8'hA5;
        m_owner    = 1'b0;
        m_a_shown  = 1'b0;
        m_b_shown  = 1'b0;
        m_pile     = '0;
        m_sa       = '0;
        m_sb       = '0;
        m_win      = WIN_NONE;
    endtask

    // one deal with the table checked two edges later
    task automatic deal_card();
        color_t  c;
        number_t n;
        m_lfsr = lfsr_step(m_lfsr);
        c      = m_lfsr[1:0];
        n      = number_t'(int'(m_lfsr[7:2]) % 5 + 1);
        deal   = 1'b1;
        next_cycle();
        deal = 1'b0;
        next_cycle();
        if (m_owner) begin
            m_b_color  = c;
            m_b_number = n;
            m_b_shown  = 1'b1;
        end else begin
            m_a_color  = c;
            m_a_number = n;
            m_a_shown  = 1'b1;
        end
        m_owner = ~m_owner;
        if (m_pile != 8'hFF) m_pile = m_pile + 8'd1;
        check_value("a_shown", 8'(a_shown), 8'(m_a_shown));
        check_value("b_shown", 8'(b_shown), 8'(m_b_shown));
        check_value("pile_count", pile_count, m_pile);
        if (m_a_shown) begin
            check_value("a_color", 8'(a_color), 8'(m_a_color));
            check_value("a_number", 8'(a_number), 8'(m_a_number));
        end
        if (m_b_shown) begin
            check_value("b_color", 8'(b_color), 8'(m_b_color));
            check_value("b_number", 8'(b_number), 8'(m_b_number));
        end
    endtask

    task automatic deal_until(input logic want);
        int n;
        n = 0;
        while (rule_holds() != want && n < DEAL_CAP) begin
            deal_card();
            n++;
        end
        if (rule_holds() != want) begin
            $display("error: no suitable table after %0d deals", n);
            errors++;
        end
    endtask

    // key held for hold cycles (3 or more)
    task automatic ring_bell(input key_t key, input int hold);
        logic    exp_right;
        logic    exp_who;
        score_t  pile;
        winner_t old_win;
        int      claims;
        exp_right = rule_holds();
        exp_who   = (key == KEY_B);
        pile      = m_pile;
        old_win   = m_win;
        claims    = 0;
        keypad    = key;
        next_cycle();   // edge K
        if (claim) claims++;
        check_value("claim", 8'(claim), 8'd1);
        check_value("claim_who", 8'(claim_who), 8'(exp_who));
        check_value("claim_right", 8'(claim_right), 8'(exp_right));
        if (exp_right) begin
            if (exp_who) m_sb = m_sb + pile;
            else         m_sa = m_sa + pile;
        end else if (exp_who) begin
            m_sb = m_sb - 8'd1;
            m_sa = m_sa + 8'd1;
        end else begin
            m_sa = m_sa - 8'd1;
            m_sb = m_sb + 8'd1;
        end
        m_pile = '0;
        m_win  = winner_for(m_sa, m_sb);
        next_cycle();
        if (claim) claims++;
        check_value("score_a", score_a, m_sa);
        check_value("score_b", score_b, m_sb);
        check_value("pile_count", pile_count, m_pile);
        check_value("winner", 8'(winner), 8'(old_win));
        next_cycle();
        if (claim) claims++;
        check_value("winner", 8'(winner), 8'(m_win));
        repeat (hold - 3) begin
            next_cycle();
            if (claim) claims++;
        end
        keypad = '0;
        next_cycle();
        if (claim) claims++;
        if (claims != 1) begin
            $display("error: %0d claim pulses for one ring instead of one", claims);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - test_start);
        end
        test_start = errors;
    endtask

    task automatic reset_values();
        check_value("a_shown", 8'(a_shown), 8'd0);
        check_value("b_shown", 8'(b_shown), 8'd0);
        check_value("pile_count", pile_count, 8'd0);
        check_value("score_a", score_a, 8'd0);
        check_value("score_b", score_b, 8'd0);
        check_value("claim", 8'(claim), 8'd0);
        check_value("winner", 8'(winner), 8'(WIN_NONE));
        finish_test("reset");
    endtask

    task automatic early_ring();
        deal_card();    // only A is showing
        ring_bell(KEY_B, 3);
        finish_test("early_ring");
    endtask

    task automatic dealing_order();
        int n;
        n = 4 + int'($urandom % 5);
        repeat (n) deal_card();
        check_value("pile_count", pile_count, 8'(n));
        finish_test("dealing");
    endtask

    task automatic right_ring();
        deal_until(1'b1);
        ring_bell(KEY_A, 3);
        finish_test("right_ring");
    endtask

    task automatic wrong_ring_lockout();
        deal_until(1'b0);
        ring_bell(KEY_B, 5);
        finish_test("wrong_ring");
    endtask

    task automatic winner_margin();
        int rings;
        rings = 0;
        apply_reset();
        while (m_win == WIN_NONE && rings < RING_CAP) begin
            repeat (8 + int'($urandom % 8)) deal_card();   // keep the pile large
            deal_until(1'b1);
            ring_bell(KEY_A, 3);
            rings++;
        end
        if (m_win != WIN_A) begin
            $display("error: player A did not win within %0d rings", rings);
            errors++;
        end
        finish_test("winner");
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b0;
        deal         = 1'b0;
        keypad       = '0;
        errors       = 0;
        test_start   = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(31));

        apply_reset();
        early_ring();
        apply_reset();  // table and scores are dirty from the early ring
        reset_values();
        dealing_order();
        right_ring();
        wrong_ring_lockout();
        winner_margin();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- halli_top.sv
`timescale 1ns/1ps

module halli_top import halli_pkg::*; #(
    parameter logic [7:0] LFSR_SEED  = 8'hA5,
    parameter score_t     WIN_MARGIN = 8'd50
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    deal,
    input  key_t    keypad,
    output color_t  a_color,
    output number_t a_number,
    output logic    a_shown,
    output color_t  b_color,
    output number_t b_number,
    output logic    b_shown,
    output score_t  pile_count,
    output logic    claim,
    output logic    claim_who,
    output logic    claim_right,
    output score_t  score_a,
    output score_t  score_b,
    output winner_t winner
);

    // dealer to table
    logic    card_valid;
    logic    card_owner;
    color_t  card_color;
    number_t card_number;

    card_dealer #(
        .LFSR_SEED   (LFSR_SEED)
    ) i_card_dealer (
        .clk         (clk),
        .rst         (rst),
        .deal        (deal),
        .card_valid  (card_valid),
        .card_owner  (card_owner),
        .card_color  (card_color),
        .card_number (card_number)
    );

    card_table i_card_table (
        .clk         (clk),
        .rst         (rst),
        .card_valid  (card_valid),
        .card_owner  (card_owner),
        .card_color  (card_color),
        .card_number (card_number),
        .claim       (claim),           // pile clear
        .a_color     (a_color),
        .a_number    (a_number),
        .a_shown     (a_shown),
        .b_color     (b_color),
        .b_number    (b_number),
        .b_shown     (b_shown),
        .pile_count  (pile_count)
    );

    bell_judge i_bell_judge (
        .clk         (clk),
        .rst         (rst),
        .keypad      (keypad),
        .a_color     (a_color),
        .a_number    (a_number),
        .a_shown     (a_shown),
        .b_color     (b_color),
        .b_number    (b_number),
        .b_shown     (b_shown),
        .claim       (claim),
        .claim_who   (claim_who),
        .claim_right (claim_right)
    );

    score_board #(
        .WIN_MARGIN  (WIN_MARGIN)
    ) i_score_board (
        .clk         (clk),
        .rst         (rst),
        .claim       (claim),
        .claim_who   (claim_who),
        .claim_right (claim_right),
        .pile_count  (pile_count),
        .score_a     (score_a),
        .score_b     (score_b),
        .winner      (winner)
    );

endmodule

//--- score_board.sv
`timescale 1ns/1ps

module score_board import halli_pkg::*; #(
    parameter score_t WIN_MARGIN = 8'd50
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    claim,
    input  logic    claim_who,
    input  logic    claim_right,
    input  score_t  pile_count,
    output score_t  score_a,
    output score_t  score_b,
    output winner_t winner
);

    score_t a_limit;
    score_t b_limit;

    // 8-bit wrap on the margin sum
    assign a_limit = score_b + WIN_MARGIN;
    assign b_limit = score_a + WIN_MARGIN;

    always_ff @(posedge clk) begin
        if (!rst) begin
            score_a <= '0;
            score_b <= '0;
        end else if (claim) begin
            if (claim_right) begin
                if (claim_who) score_b <= score_b + pile_count;
                else           score_a <= score_a + pile_count;
            end else if (claim_who) begin
                score_b <= score_b - 8'd1;  // penalty goes to the other side
                score_a <= score_a + 8'd1;
            end else begin
                score_a <= score_a - 8'd1;
                score_b <= score_b + 8'd1;
            end
        end
    end

    // one cycle behind the scores
    always_ff @(posedge clk) begin
        if (!rst) begin
            winner <= WIN_NONE;
        end else if (score_a > a_limit) begin
            winner <= WIN_A;
        end else if (score_b > b_limit) begin
            winner <= WIN_B;
        end else begin
            winner <= WIN_NONE;
        end
    end

endmodule

//--- bell_judge.sv
`timescale 1ns/1ps

module bell_judge import halli_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  key_t    keypad,
    input  color_t  a_color,
    input  number_t a_number,
    input  logic    a_shown,
    input  color_t  b_color,
    input  number_t b_number,
    input  logic    b_shown,
    output logic    claim,
    output logic    claim_who,
    output logic    claim_right
);

    typedef enum logic {
        IDLE   = 1'b0,
        LOCKED = 1'b1
    } state_t;

    state_t     state;
    logic       key_a;
    logic       key_b;
    logic       ring;
    logic [3:0] num_sum;
    logic       same_color;
    logic       has_five;
    logic       ring_ok;

    assign key_a = (keypad == KEY_A);
    assign key_b = (keypad == KEY_B);
    assign ring  = (state == IDLE) && (key_a || key_b);

    // ring rule against the current table
    assign num_sum    = {1'b0, a_number} + {1'b0, b_number};
    assign same_color = (a_color == b_color);
    assign has_five   = (a_number == 3'd5) || (b_number == 3'd5);

    assign ring_ok = a_shown && b_shown &&
                     (same_color ? (num_sum == 4'd5) : has_five);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= IDLE;
            claim <= 1'b0;
        end else begin
            claim <= 1'b0;
            case (state)
                IDLE: begin
                    if (key_a || key_b) begin
                        state <= LOCKED;
                        claim <= 1'b1;
                    end
                end
                LOCKED: begin
                    if (!key_a && !key_b) state <= IDLE;   // wait for release
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ring) begin
            claim_who   <= !key_a;  // A first
            claim_right <= ring_ok;
        end
    end

    // a held key must not claim twice
    a_claim_pulse: assert property (@(posedge clk) disable iff (!rst)
        claim |=> !claim);

endmodule

//--- card_table.sv
`timescale 1ns/1ps

module card_table import halli_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    card_valid,
    input  logic    card_owner,
    input  color_t  card_color,
    input  number_t card_number,
    input  logic    claim,
    output color_t  a_color,
    output number_t a_number,
    output logic    a_shown,
    output color_t  b_color,
    output number_t b_number,
    output logic    b_shown,
    output score_t  pile_count
);

    logic pile_full;

    assign pile_full = (pile_count == 8'hFF);

    // shown flags and pile count
    always_ff @(posedge clk) begin
        if (!rst) begin
            a_shown    <= 1'b0;
            b_shown    <= 1'b0;
            pile_count <= '0;
        end else begin
            if (card_valid && !card_owner) a_shown <= 1'b1;
            if (card_valid && card_owner)  b_shown <= 1'b1;

            if (claim) begin
                pile_count <= card_valid ? 8'd1 : 8'd0;    // card laid as pile is taken
            end else if (card_valid && !pile_full) begin
                pile_count <= pile_count + 8'd1;
            end
        end
    end

    // top cards are kept across claims
    always_ff @(posedge clk) begin
        if (card_valid) begin
            if (card_owner) begin
                b_color  <= card_color;
                b_number <= card_number;
            end else begin
                a_color  <= card_color;
                a_number <= card_number;
            end
        end
    end

    // only a claim from the judge may shrink the pile
    a_pile_monotonic: assert property (@(posedge clk) disable iff (!rst)
        !claim |=> pile_count >= $past(pile_count));

endmodule

//--- card_dealer.sv
`timescale 1ns/1ps

module card_dealer import halli_pkg::*; #(
    parameter logic [7:0] LFSR_SEED = 8'hA5
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    deal,
    output logic    card_valid,
    output logic    card_owner,
    output color_t  card_color,
    output number_t card_number
);

    logic [7:0] lfsr;
    logic [7:0] lfsr_next;
    logic       feedback;
    logic       next_owner;     // 0 = A
    number_t    num_mod;

    // taps 8,6,5,4 shifting left
    assign feedback  = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
    assign lfsr_next = {lfsr[6:0], feedback};

    assign num_mod = number_t'(lfsr_next[7:2] % 6'd5);

    always_ff @(posedge clk) begin
        if (!rst) begin
            lfsr       <= LFSR_SEED;
            next_owner <= 1'b0;
            card_valid <= 1'b0;
        end else begin
            card_valid <= deal;
            if (deal) begin
                lfsr       <= lfsr_next;
                next_owner <= ~next_owner;
            end
        end
    end

    // card fields from the stepped state
    always_ff @(posedge clk) begin
        if (deal) begin
            card_owner  <= next_owner;
            card_color  <= lfsr_next[1:0];
            card_number <= num_mod + 3'd1;
        end
    end

    // every dealt card is a legal card
    a_card_range: assert property (@(posedge clk) disable iff (!rst)
        card_valid |-> (card_number >= 3'd1) && (card_number <= 3'd5));

endmodule

//--- halli_pkg.sv
package halli_pkg;

    // card fields
    typedef logic [1:0] color_t;
    typedef logic [2:0] number_t;   // only 1..5 are dealt

    // scores wrap as 8-bit two's complement, pile count is unsigned
    typedef logic [7:0] score_t;

    typedef logic [3:0] key_t;

    // bell keys on the keypad
    localparam key_t KEY_A = 4'd7;
    localparam key_t KEY_B = 4'd9;

    typedef enum logic [1:0] {
        WIN_NONE = 2'd0,
        WIN_A    = 2'd1,
        WIN_B    = 2'd2
    } winner_t;

endpackage
